/* design/sdmac_macros.svh */
// Widths and offsets are fixed for the 8-bit offset map; VERSION writes are ignored by design
`ifndef SDMAC_MACROS_SVH
`define SDMAC_MACROS_SVH

`define SDMAC_ADDR_W 8                  // CPU register offset width
`define SDMAC_DATA_W 32                 // Register and bus word width

// Register offsets
`define SDMAC_OFS_WTC     8'h04         // Word transfer count, read only
`define SDMAC_OFS_CONTR   8'h08         // Control register
`define SDMAC_OFS_ACR     8'h0C         // Address counter, write only
`define SDMAC_OFS_ST_DMA  8'h10         // Start DMA on any access
`define SDMAC_OFS_FLUSH   8'h14         // Flush, sets flush done
`define SDMAC_OFS_CLR_INT 8'h18         // Clear interrupt
`define SDMAC_OFS_ISTR    8'h1C         // Interrupt status, read only
`define SDMAC_OFS_VERSION 8'h20         // Fixed version word
`define SDMAC_OFS_SP_DMA  8'h3C         // Stop DMA on any access
`define SDMAC_OFS_SSPBDAT 8'h58         // Data port

// External SCSI chip window, offsets 0x40 to 0x4F
`define SDMAC_WD_PAGE 4'h4

`define SDMAC_VERSION 32'h5344_0001     // Read value of the VERSION register

// Bytes per beat, ACR advances by one 32-bit word
`define SDMAC_ACR_STEP 32'd4

`endif

/* design/sdmac_pkg.sv */
// Reserved bits in CONTR and ISTR always read as zero; bit positions follow the SDMAC layout
package sdmac_pkg;

`include "sdmac_macros.svh"

  // Control register, only three bits are kept
  typedef struct packed {
    logic [26:0] rsvd_hi;     // [31:5]
    logic        reset_pend;  // [4] Peripheral reset request
    logic        rsvd_3;      // [3]
    logic        inten;       // [2] Interrupt enable
    logic        dmadir;      // [1] 1 = host to SCSI
    logic        rsvd_0;      // [0]
  } contr_t;

  // Interrupt status
  typedef struct packed {
    logic [26:0] rsvd_hi;     // [31:5]
    logic        int_p;       // [4] Sticky SCSI interrupt
    logic [1:0]  rsvd_mid;    // [3:2]
    logic        dma_act;     // [1] Mirror of DMA active
    logic        fe;          // [0] Flush done
  } istr_t;

  // Register snapshot from execute to result
  typedef struct packed {
    logic [`SDMAC_DATA_W-1:0] wtc;
    contr_t                   contr;
    logic [`SDMAC_DATA_W-1:0] acr;
    istr_t                    istr;
    logic [`SDMAC_DATA_W-1:0] sspbdat;
  } sdmac_regs_t;

endpackage

/* design/sdmac_dec_if.sv */
// Strobes are single-cycle and only high in the cycle a request is accepted
`timescale 1ns/1ps

interface sdmac_dec_if;

  // Register read strobes
  logic wtc_rd;
  logic contr_rd;
  logic istr_rd;
  logic sspbdat_rd;
  logic version_rd;

  // Register write strobes
  logic contr_wr;
  logic acr_wr;
  logic sspbdat_wr;

  // Action strobes, fire on read or write
  logic st_dma;
  logic sp_dma;
  logic clr_int;
  logic flush;

  logic wd_hit;   // External SCSI chip window

  modport decode (
    output wtc_rd, contr_rd, istr_rd, sspbdat_rd, version_rd,
    output contr_wr, acr_wr, sspbdat_wr,
    output st_dma, sp_dma, clr_int, flush,
    output wd_hit
  );

  modport execute (
    input contr_wr, acr_wr, sspbdat_wr,
    input st_dma, sp_dma, clr_int, flush
  );

  modport result (
    input wtc_rd, contr_rd, istr_rd, sspbdat_rd, version_rd,
    input wd_hit
  );

endinterface

/* design/addr_decoder.sv */
// Purely combinational; addr and rw must be stable while accept is high
`timescale 1ns/1ps

`include "sdmac_macros.svh"

module addr_decoder (
  input  logic                     accept,  // Request accepted this cycle
  input  logic [`SDMAC_ADDR_W-1:0] addr,    // Register offset
  input  logic                     rw,      // 1 = read
  sdmac_dec_if.decode              dec
);

  logic h_04;
  logic h_08;
  logic h_0c;
  logic h_10;
  logic h_14;
  logic h_18;
  logic h_1c;
  logic h_20;
  logic h_3c;
  logic h_58;

  // Offset hits, only during an accepted request
  assign h_04 = accept & (addr == `SDMAC_OFS_WTC);
  assign h_08 = accept & (addr == `SDMAC_OFS_CONTR);
  assign h_0c = accept & (addr == `SDMAC_OFS_ACR);
  assign h_10 = accept & (addr == `SDMAC_OFS_ST_DMA);
  assign h_14 = accept & (addr == `SDMAC_OFS_FLUSH);
  assign h_18 = accept & (addr == `SDMAC_OFS_CLR_INT);
  assign h_1c = accept & (addr == `SDMAC_OFS_ISTR);
  assign h_20 = accept & (addr == `SDMAC_OFS_VERSION);
  assign h_3c = accept & (addr == `SDMAC_OFS_SP_DMA);
  assign h_58 = accept & (addr == `SDMAC_OFS_SSPBDAT);

  assign dec.wd_hit = accept & (addr[7:4] == `SDMAC_WD_PAGE);

  // Read strobes
  assign dec.wtc_rd     = h_04 & rw;
  assign dec.contr_rd   = h_08 & rw;
  assign dec.istr_rd    = h_1c & rw;
  assign dec.sspbdat_rd = h_58 & rw;
  assign dec.version_rd = h_20 & rw;

  // Write strobes, a VERSION write has none
  assign dec.contr_wr   = h_08 & ~rw;
  assign dec.acr_wr     = h_0c & ~rw;
  assign dec.sspbdat_wr = h_58 & ~rw;

  // Actions ignore the direction
  assign dec.st_dma  = h_10;
  assign dec.sp_dma  = h_3c;
  assign dec.clr_int = h_18;
  assign dec.flush   = h_14;

endmodule

/* design/sdmac_regs.sv */
// Beats count only while DMA is active; a start in the same cycle as a beat wins
`timescale 1ns/1ps

`include "sdmac_macros.svh"

module sdmac_regs
  import sdmac_pkg::*;
(
  input  logic                     clk,
  input  logic                     arst_n,
  sdmac_dec_if.execute             dec,
  input  logic [`SDMAC_DATA_W-1:0] wdata,
  input  logic                     dma_beat,   // One pulse per moved word
  input  logic                     scsi_int,   // Level from the SCSI chip
  output sdmac_regs_t              regs,
  output logic                     dma_active,
  output logic                     irq
);

  contr_t                   contr_q;
  contr_t                   contr_word;
  contr_t                   contr_in;
  istr_t                    istr;
  logic [`SDMAC_DATA_W-1:0] acr_q;
  logic [`SDMAC_DATA_W-1:0] wtc_q;
  logic [`SDMAC_DATA_W-1:0] sspbdat_q;
  logic                     int_p_q;
  logic                     fe_q;
  logic                     active_q;
  logic                     beat_ok;

  assign contr_word = contr_t'(wdata);

  // Keep only the implemented control bits
  always_comb begin
    contr_in            = '0;
    contr_in.dmadir     = contr_word.dmadir;
    contr_in.inten      = contr_word.inten;
    contr_in.reset_pend = contr_word.reset_pend;
  end

  assign beat_ok = dma_beat & active_q & ~dec.st_dma;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      contr_q   <= '0;
      sspbdat_q <= '0;
    end else begin
      if (dec.contr_wr) begin
        contr_q <= contr_in;
      end
      if (dec.sspbdat_wr) begin
        sspbdat_q <= wdata;
      end
    end
  end

  // Address and word counters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acr_q <= '0;
      wtc_q <= '0;
    end else begin
      if (dec.acr_wr) begin
        acr_q <= wdata;                      // CPU load has priority
      end else if (beat_ok) begin
        acr_q <= acr_q + `SDMAC_ACR_STEP;
      end
      if (dec.st_dma) begin
        wtc_q <= '0;
      end else if (beat_ok) begin
        wtc_q <= wtc_q + `SDMAC_DATA_W'(1);
      end
    end
  end

  // DMA state, interrupt and flush flags
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      active_q <= 1'b0;
      int_p_q  <= 1'b0;
      fe_q     <= 1'b0;
    end else begin
      if (dec.st_dma) begin
        active_q <= 1'b1;
      end else if (dec.sp_dma) begin
        active_q <= 1'b0;
      end
      if (dec.clr_int) begin
        int_p_q <= 1'b0;                     // Clear beats a new interrupt
      end else if (scsi_int) begin
        int_p_q <= 1'b1;
      end
      if (dec.st_dma) begin
        fe_q <= 1'b0;
      end else if (dec.flush) begin
        fe_q <= 1'b1;                        // No FIFO, flush completes at once
      end
    end
  end

  always_comb begin
    istr         = '0;
    istr.int_p   = int_p_q;
    istr.fe      = fe_q;
    istr.dma_act = active_q;
  end

  always_comb begin
    regs.wtc     = wtc_q;
    regs.contr   = contr_q;
    regs.acr     = acr_q;
    regs.istr    = istr;
    regs.sspbdat = sspbdat_q;
  end

  assign dma_active = active_q;
  assign irq        = int_p_q & contr_q.inten;

endmodule

/* design/sdmac_resp.sv */
// One outstanding request; read data is the register value before the same access
`timescale 1ns/1ps

`include "sdmac_macros.svh"

module sdmac_resp
  import sdmac_pkg::*;
(
  input  logic                     clk,
  input  logic                     arst_n,
  sdmac_dec_if.result              dec,
  input  sdmac_regs_t              regs,
  input  logic                     accept,
  input  logic                     rsp_ready,
  output logic                     rsp_valid,
  output logic [`SDMAC_DATA_W-1:0] rsp_rdata,
  output logic                     wd_sel,     // One-cycle chip select pulse
  output logic                     req_ready
);

  logic [`SDMAC_DATA_W-1:0] rd_word;
  logic                     valid_q;
  logic [`SDMAC_DATA_W-1:0] rdata_q;
  logic                     wd_sel_q;

  // At most one read strobe is high, writes and misses give zero
  assign rd_word = ({`SDMAC_DATA_W{dec.wtc_rd}}     & regs.wtc)
                 | ({`SDMAC_DATA_W{dec.contr_rd}}   & regs.contr)
                 | ({`SDMAC_DATA_W{dec.istr_rd}}    & regs.istr)
                 | ({`SDMAC_DATA_W{dec.sspbdat_rd}} & regs.sspbdat)
                 | ({`SDMAC_DATA_W{dec.version_rd}} & `SDMAC_VERSION);

  // Free when empty or when the held response leaves this cycle
  assign req_ready = ~valid_q | rsp_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      rdata_q <= '0;
    end else begin
      if (accept) begin
        valid_q <= 1'b1;
        rdata_q <= rd_word;
      end else if (rsp_ready) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wd_sel_q <= 1'b0;
    end else begin
      wd_sel_q <= dec.wd_hit;
    end
  end

  assign rsp_valid = valid_q;
  assign rsp_rdata = rdata_q;
  assign wd_sel    = wd_sel_q;

endmodule

/* design/sdmac_top.sv */
// Register block only; no data mover, FIFO or bus-width conversion behind dma_beat
`timescale 1ns/1ps

`include "sdmac_macros.svh"

module sdmac_top
  import sdmac_pkg::*;
(
  input  logic                     clk,
  input  logic                     arst_n,

  // CPU request
  input  logic                     req_valid,
  output logic                     req_ready,
  input  logic [`SDMAC_ADDR_W-1:0] req_addr,
  input  logic                     req_rw,      // 1 = read
  input  logic [`SDMAC_DATA_W-1:0] req_wdata,

  // CPU response
  output logic                     rsp_valid,
  input  logic                     rsp_ready,
  output logic [`SDMAC_DATA_W-1:0] rsp_rdata,

  // DMA and interrupt side
  input  logic                     dma_beat,
  input  logic                     scsi_int,
  output logic                     dma_active,
  output logic                     dma_dir,
  output logic [`SDMAC_DATA_W-1:0] dma_addr,    // Current ACR
  output logic                     irq,
  output logic                     wd_sel
);

  sdmac_dec_if dec_if ();

  sdmac_regs_t regs;
  logic        accept;

  assign accept = req_valid & req_ready;

  addr_decoder addr_decoder_i (
    .accept (accept),
    .addr   (req_addr),
    .rw     (req_rw),
    .dec    (dec_if.decode)
  );

  sdmac_regs sdmac_regs_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .dec        (dec_if.execute),
    .wdata      (req_wdata),
    .dma_beat   (dma_beat),
    .scsi_int   (scsi_int),
    .regs       (regs),
    .dma_active (dma_active),
    .irq        (irq)
  );

  sdmac_resp sdmac_resp_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec       (dec_if.result),
    .regs      (regs),
    .accept    (accept),
    .rsp_ready (rsp_ready),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .wd_sel    (wd_sel),
    .req_ready (req_ready)
  );

  assign dma_dir  = regs.contr.dmadir;
  assign dma_addr = regs.acr;

endmodule

/* bench/sdmac_tb_tasks.svh */
// Included inside sdmac_tb; every task starts and ends 5 ns after a rising clock edge
`ifndef SDMAC_TB_TASKS_SVH
`define SDMAC_TB_TASKS_SVH

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp);
    errors++;
  end
endtask

task automatic check_contr(input string name, input contr_t got, input contr_t exp);
  if (got !== exp) begin
    $display("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp);
    errors++;
  end
endtask

task automatic check_istr(input string name, input istr_t got, input istr_t exp);
  if (got !== exp) begin
    $display("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp);
    errors++;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
    errors++;
  end
endtask

task automatic finish_test(input string name, input int err0);
  tests_run++;
  if (errors == err0) begin
    tests_passed++;
    $display("PASS %s", name);
  end else begin
    $display("FAIL %s: %0d check(s) failed", name, errors - err0);
  end
endtask

// Only dmadir, inten and reset_pend survive a write
function automatic contr_t used_contr(input logic [31:0] w);
  contr_t c;
  contr_t x;
  x            = contr_t'(w);
  c            = '0;
  c.dmadir     = x.dmadir;
  c.inten      = x.inten;
  c.reset_pend = x.reset_pend;
  return c;
endfunction

function automatic istr_t make_istr(input logic int_p, input logic fe, input logic act);
  istr_t s;
  s         = '0;
  s.int_p   = int_p;
  s.fe      = fe;
  s.dma_act = act;
  return s;
endfunction

task automatic bus_access(input logic [7:0] addr, input logic rw, input logic [31:0] wdata,
                          output logic [31:0] rdata);
  int waited;
  req_valid = 1'b1;
  req_addr  = addr;
  req_rw    = rw;
  req_wdata = wdata;
  rdata     = '0;
  waited    = 0;
  @(negedge clk);
  while (!req_ready && waited < 20) begin
    @(negedge clk);
    waited++;
  end
  @(posedge clk);                        // Accepted here
  #5;
  req_valid = 1'b0;
  @(negedge clk);
  while (!rsp_valid && waited < 20) begin
    @(negedge clk);
    waited++;
  end
  if (waited >= 20) begin
    $display("Error: the access to offset 0x%02h got no response", addr);
    errors++;
  end
  rdata = rsp_rdata;
  @(posedge clk);                        // Response taken, rsp_ready is high
  #5;
endtask

task automatic bus_write(input logic [7:0] addr, input logic [31:0] wdata);
  logic [31:0] rd;
  bus_access(addr, 1'b0, wdata, rd);
  check_word("rsp_rdata", rd, '0);       // Writes answer with zero
endtask

task automatic bus_read(input logic [7:0] addr, output logic [31:0] rdata);
  bus_access(addr, 1'b1, '0, rdata);
endtask

task automatic pulse_beats(input int n);
  dma_beat = 1'b1;
  repeat (n) @(posedge clk);
  #5;
  dma_beat = 1'b0;
endtask

task automatic test_reset_values();
  int          err0;
  logic [31:0] rd;
  err0 = errors;
  check_bit("dma_active", dma_active, 1'b0);
  check_bit("irq", irq, 1'b0);
  bus_read(`SDMAC_OFS_CONTR, rd);
  check_contr("CONTR", contr_t'(rd), '0);
  bus_read(`SDMAC_OFS_ISTR, rd);
  check_istr("ISTR", istr_t'(rd), '0);
  bus_read(`SDMAC_OFS_WTC, rd);
  check_word("WTC", rd, '0);
  bus_read(`SDMAC_OFS_SSPBDAT, rd);
  check_word("SSPBDAT", rd, '0);
  bus_read(`SDMAC_OFS_VERSION, rd);
  check_word("VERSION", rd, `SDMAC_VERSION);
  bus_read(8'h30, rd);                   // Unmapped
  check_word("rsp_rdata", rd, '0);
  finish_test("reset values", err0);
endtask

task automatic test_reg_access();
  int          err0;
  logic [31:0] w;
  logic [31:0] rd;
  contr_t      exp_c;
  err0 = errors;
  repeat (3) begin
    w     = lcg_next();
    exp_c = used_contr(w);
    bus_write(`SDMAC_OFS_CONTR, w);
    check_bit("dma_dir", dma_dir, exp_c.dmadir);
    bus_read(`SDMAC_OFS_CONTR, rd);
    check_contr("CONTR", contr_t'(rd), exp_c);
    w = lcg_next();
    bus_write(`SDMAC_OFS_SSPBDAT, w);
    bus_read(`SDMAC_OFS_SSPBDAT, rd);
    check_word("SSPBDAT", rd, w);
  end
  w = lcg_next();
  bus_write(`SDMAC_OFS_ACR, w);
  check_word("dma_addr", dma_addr, w);
  bus_read(`SDMAC_OFS_ACR, rd);          // Write only
  check_word("ACR", rd, '0);
  bus_write(`SDMAC_OFS_VERSION, lcg_next());
  bus_read(`SDMAC_OFS_VERSION, rd);
  check_word("VERSION", rd, `SDMAC_VERSION);
  finish_test("register access", err0);
endtask

task automatic test_dma_counting();
  int          err0;
  int          n;
  logic [31:0] base;
  logic [31:0] rd;
  err0 = errors;
  base = lcg_next();
  n    = 3 + int'(lcg_next() % 6);
  bus_write(`SDMAC_OFS_ACR, base);
  bus_write(`SDMAC_OFS_ST_DMA, '0);
  check_bit("dma_active", dma_active, 1'b1);
  pulse_beats(n);
  check_word("dma_addr", dma_addr, base + 32'(n) * `SDMAC_ACR_STEP);
  bus_read(`SDMAC_OFS_WTC, rd);
  check_word("WTC", rd, 32'(n));
  bus_read(`SDMAC_OFS_ISTR, rd);
  check_istr("ISTR", istr_t'(rd), make_istr(1'b0, 1'b0, 1'b1));
  bus_read(`SDMAC_OFS_SP_DMA, rd);       // A read stops DMA as well
  check_word("rsp_rdata", rd, '0);
  check_bit("dma_active", dma_active, 1'b0);
  pulse_beats(3);                        // Ignored while stopped
  check_word("dma_addr", dma_addr, base + 32'(n) * `SDMAC_ACR_STEP);
  bus_read(`SDMAC_OFS_WTC, rd);
  check_word("WTC", rd, 32'(n));
  finish_test("DMA counting", err0);
endtask

task automatic test_interrupts();
  int          err0;
  contr_t      c;
  logic [31:0] rd;
  err0 = errors;
  bus_write(`SDMAC_OFS_CONTR, '0);
  scsi_int = 1'b1;
  @(posedge clk);
  #5;
  scsi_int = 1'b0;
  bus_read(`SDMAC_OFS_ISTR, rd);
  check_istr("ISTR", istr_t'(rd), make_istr(1'b1, 1'b0, 1'b0));
  check_bit("irq", irq, 1'b0);           // Masked
  c       = '0;
  c.inten = 1'b1;
  bus_write(`SDMAC_OFS_CONTR, 32'(c));
  check_bit("irq", irq, 1'b1);
  bus_read(`SDMAC_OFS_CLR_INT, rd);
  check_word("rsp_rdata", rd, '0);
  check_bit("irq", irq, 1'b0);
  bus_read(`SDMAC_OFS_ISTR, rd);
  check_istr("ISTR", istr_t'(rd), make_istr(1'b0, 1'b0, 1'b0));
  bus_write(`SDMAC_OFS_FLUSH, '0);
  bus_read(`SDMAC_OFS_ISTR, rd);
  check_istr("ISTR", istr_t'(rd), make_istr(1'b0, 1'b1, 1'b0));
  bus_write(`SDMAC_OFS_ST_DMA, '0);
  bus_read(`SDMAC_OFS_ISTR, rd);
  check_istr("ISTR", istr_t'(rd), make_istr(1'b0, 1'b0, 1'b1));
  bus_write(`SDMAC_OFS_SP_DMA, '0);
  finish_test("interrupts and flush", err0);
endtask

task automatic test_back_pressure();
  int          err0;
  int          stall;
  logic [31:0] w;
  err0 = errors;
  repeat (2) begin
    w     = lcg_next();
    stall = 2 + int'(lcg_next() % 8);
    bus_write(`SDMAC_OFS_SSPBDAT, w);
    rsp_ready = 1'b0;
    req_valid = 1'b1;
    req_addr  = `SDMAC_OFS_SSPBDAT;
    req_rw    = 1'b1;
    @(negedge clk);
    check_bit("req_ready", req_ready, 1'b1);
    @(posedge clk);                      // First read accepted
    #5;
    req_addr = `SDMAC_OFS_VERSION;       // Second read waits behind it
    repeat (stall) begin
      @(negedge clk);
      check_bit("rsp_valid", rsp_valid, 1'b1);
      check_word("rsp_rdata", rsp_rdata, w);
      check_bit("req_ready", req_ready, 1'b0);
    end
    @(posedge clk);
    #5;
    rsp_ready = 1'b1;
    @(negedge clk);
    check_bit("req_ready", req_ready, 1'b1);
    check_word("rsp_rdata", rsp_rdata, w);
    @(posedge clk);                      // First taken, second accepted
    #5;
    req_valid = 1'b0;
    @(negedge clk);
    check_bit("rsp_valid", rsp_valid, 1'b1);
    check_word("rsp_rdata", rsp_rdata, `SDMAC_VERSION);
    @(posedge clk);
    #5;
    @(negedge clk);
    check_bit("rsp_valid", rsp_valid, 1'b0);
    @(posedge clk);
    #5;
  end
  finish_test("back-pressure", err0);
endtask

task automatic test_wd_window();
  int          err0;
  int          ofs;
  logic [31:0] rd;
  logic [7:0]  other [4];
  err0  = errors;
  other = '{8'h3F, 8'h50, 8'h30, 8'h20};
  for (ofs = 0; ofs < 16; ofs++) begin
    wd_count = 0;
    if (ofs % 2 == 1) begin
      bus_write(8'(8'h40 + ofs), lcg_next());
    end else begin
      bus_read(8'(8'h40 + ofs), rd);
      check_word("rsp_rdata", rd, '0);
    end
    check_word("wd_sel cycles", 32'(wd_count), 32'd1);
  end
  foreach (other[i]) begin
    wd_count = 0;
    bus_read(other[i], rd);
    check_word("wd_sel cycles", 32'(wd_count), 32'd0);
  end
  finish_test("external chip window", err0);
endtask

`endif

/* bench/sdmac_tb.sv */
// Needs design/ and bench/ on the include path; the watchdog stops a hung run after a fixed limit
`timescale 1ns/1ps

`include "sdmac_macros.svh"

module sdmac_tb
  import sdmac_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  // Reset plus the planned cycles of the six tests
  localparam int PLAN_CYCLES = 4 + 30 + 80 + 50 + 50 + 80 + 80;

  logic                     clk = 1'b0;
  logic                     arst_n;
  logic                     req_valid;
  logic                     req_ready;
  logic [`SDMAC_ADDR_W-1:0] req_addr;
  logic                     req_rw;
  logic [`SDMAC_DATA_W-1:0] req_wdata;
  logic                     rsp_valid;
  logic                     rsp_ready;
  logic [`SDMAC_DATA_W-1:0] rsp_rdata;
  logic                     dma_beat;
  logic                     scsi_int;
  logic                     dma_active;
  logic                     dma_dir;
  logic [`SDMAC_DATA_W-1:0] dma_addr;
  logic                     irq;
  logic                     wd_sel;

  int          errors       = 0;
  int          tests_run    = 0;
  int          tests_passed = 0;
  int          wd_count     = 0;   // wd_sel cycles seen since the last clear
  logic [31:0] lcg_state    = 32'd76204;

  always #(CLK_PERIOD / 2) clk = ~clk;

  sdmac_top sdmac_top_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_addr   (req_addr),
    .req_rw     (req_rw),
    .req_wdata  (req_wdata),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp_rdata  (rsp_rdata),
    .dma_beat   (dma_beat),
    .scsi_int   (scsi_int),
    .dma_active (dma_active),
    .dma_dir    (dma_dir),
    .dma_addr   (dma_addr),
    .irq        (irq),
    .wd_sel     (wd_sel)
  );

  always @(negedge clk) begin
    if (wd_sel) begin
      wd_count++;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  `include "sdmac_tb_tasks.svh"

  initial begin
    #(PLAN_CYCLES * 4 * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d ns", PLAN_CYCLES * 4 * CLK_PERIOD);
    $display("Verification failed");
    $finish;
  end

  initial begin
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    req_rw    = 1'b0;
    req_wdata = '0;
    rsp_ready = 1'b1;
    dma_beat  = 1'b0;
    scsi_int  = 1'b0;
    repeat (4) @(posedge clk);
    #5;
    arst_n = 1'b1;
    test_reset_values();
    test_reg_access();
    test_dma_counting();
    test_interrupts();
    test_back_pressure();
    test_wd_window();
    $display("Tests run: %0d, passed: %0d, failed: %0d, failed checks: %0d",
             tests_run, tests_passed, tests_run - tests_passed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+design
+incdir+bench
design/sdmac_pkg.sv
design/sdmac_dec_if.sv
design/addr_decoder.sv
design/sdmac_regs.sv
design/sdmac_resp.sv
design/sdmac_top.sv
bench/sdmac_tb.sv

/* Bender.yml */
package:
  name: sdmac

export_include_dirs:
  - design

sources:
  - files:
      - design/sdmac_pkg.sv
      - design/sdmac_dec_if.sv
      - design/addr_decoder.sv
      - design/sdmac_regs.sv
      - design/sdmac_resp.sv
      - design/sdmac_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/sdmac_tb.sv
